//--- common/cache_pkg.sv
package cache_pkg;

   // word addresses, not byte addresses
   localparam int ADDR_W = 14;
   localparam int DATA_W = 32;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   // all zeros marks a read
   typedef logic [3:0]        strb_t;
   typedef logic [31:0]       cnt_t;

   typedef struct packed {
      addr_t addr;
      data_t data;
      strb_t strb;
   } fe_req_t;

   // zero data on a write acknowledge
   typedef struct packed {
      data_t data;
   } fe_rsp_t;

   typedef struct packed {
      addr_t addr;
      data_t data;
      strb_t strb;
      logic  we;
   } be_req_t;

   typedef struct packed {
      data_t data;
   } be_rsp_t;

   typedef enum logic [1:0] {
      stat_rd_hit,
      stat_rd_miss,
      stat_wr_hit,
      stat_wr_miss
   } stat_sel_t;

   typedef enum logic [2:0] {
      idle,
      lookup,
      refill_req,
      refill_wait,
      write_thru,
      respond
   } ctrl_state_t;

endpackage

//--- cache/way_replace.sv
module way_replace #(
   parameter int NWAYS  = 2,
   parameter int NSETS  = 16,
   localparam int WAY_W = (NWAYS > 1) ? $clog2(NWAYS) : 1,
   localparam int SET_W = $clog2(NSETS)
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic [SET_W-1:0] set_i,
   input  logic             adv_i,
   output logic [WAY_W-1:0] victim_o
);

   // one round-robin pointer per set
   logic [WAY_W-1:0] ptr_q [NSETS];

   assign victim_o = ptr_q[set_i];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int s = 0; s < NSETS; s++) begin
            ptr_q[s] <= '0;
         end
      end else if (adv_i) begin
         if (ptr_q[set_i] == WAY_W'(NWAYS - 1)) begin
            ptr_q[set_i] <= '0;
         end else begin
            ptr_q[set_i] <= ptr_q[set_i] + 1'b1;
         end
      end
   end

endmodule

//--- cache/cache_mem.sv
module cache_mem import cache_pkg::*; #(
   parameter int NWAYS      = 2,
   parameter int NSETS      = 16,
   parameter int LINE_WORDS = 4,
   localparam int WAY_W     = (NWAYS > 1) ? $clog2(NWAYS) : 1,
   localparam int SET_W     = $clog2(NSETS),
   localparam int WORD_W    = $clog2(LINE_WORDS),
   localparam int TAG_W     = ADDR_W - SET_W - WORD_W
) (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic [SET_W-1:0]            rd_set_i,
   input  logic [WORD_W-1:0]           rd_word_i,
   output logic [NWAYS-1:0][TAG_W-1:0] tags_o,
   output logic [NWAYS-1:0]            valids_o,
   output data_t [NWAYS-1:0]           words_o,
   input  logic                        wr_en_i,
   input  logic [SET_W-1:0]            wr_set_i,
   input  logic [WAY_W-1:0]            wr_way_i,
   input  logic [WORD_W-1:0]           wr_word_i,
   input  data_t                       wr_data_i,
   input  strb_t                       wr_strb_i,
   input  logic                        tag_wr_i,
   input  logic [TAG_W-1:0]            tag_i,
   input  logic                        inval_all_i
);

   logic [TAG_W-1:0] tag_mem [NWAYS][NSETS];
   data_t            data_mem [NWAYS][NSETS*LINE_WORDS];
   logic [NWAYS-1:0][NSETS-1:0] valid_q;

   // byte-strobed word write
   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         for (int b = 0; b < 4; b++) begin
            if (wr_strb_i[b]) begin
               data_mem[wr_way_i][{wr_set_i, wr_word_i}][8*b +: 8] <= wr_data_i[8*b +: 8];
            end
         end
      end
      if (tag_wr_i) begin
         tag_mem[wr_way_i][wr_set_i] <= tag_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || inval_all_i) begin
         valid_q <= '0;
      end else if (tag_wr_i) begin
         valid_q[wr_way_i][wr_set_i] <= 1'b1;
      end
   end

   // registered read of every way, old data on a same-edge write
   always_ff @(posedge clk_i) begin
      for (int w = 0; w < NWAYS; w++) begin
         tags_o[w]   <= tag_mem[w][rd_set_i];
         valids_o[w] <= valid_q[w][rd_set_i];
         words_o[w]  <= data_mem[w][{rd_set_i, rd_word_i}];
      end
   end

   a_way_range: assert property (@(posedge clk_i) disable iff (rst_i)
      (wr_en_i || tag_wr_i) |-> int'(wr_way_i) < NWAYS);

endmodule

//--- cache/cache_ctrl.sv
module cache_ctrl import cache_pkg::*; #(
   parameter int NWAYS      = 2,
   parameter int NSETS      = 16,
   parameter int LINE_WORDS = 4,
   localparam int WAY_W     = (NWAYS > 1) ? $clog2(NWAYS) : 1,
   localparam int SET_W     = $clog2(NSETS),
   localparam int WORD_W    = $clog2(LINE_WORDS),
   localparam int TAG_W     = ADDR_W - SET_W - WORD_W
) (
   input  logic                       clk_i,
   input  logic                       rst_i,
   // front end
   input  logic                       fe_req_valid_i,
   input  fe_req_t                    fe_req_i,
   output logic                       fe_req_ready_o,
   output logic                       fe_rsp_valid_o,
   output fe_rsp_t                    fe_rsp_o,
   input  logic                       fe_rsp_ready_i,
   // back end
   output logic                       be_req_valid_o,
   output be_req_t                    be_req_o,
   input  logic                       be_req_ready_i,
   input  logic                       be_rsp_valid_i,
   input  be_rsp_t                    be_rsp_i,
   output logic                       be_rsp_ready_o,
   input  logic                       invalidate_i,
   // array read side
   output logic [SET_W-1:0]           rd_set_o,
   output logic [WORD_W-1:0]          rd_word_o,
   input  logic [NWAYS-1:0][TAG_W-1:0] tags_i,
   input  logic [NWAYS-1:0]           valids_i,
   input  data_t [NWAYS-1:0]          words_i,
   // array write side
   output logic                       wr_en_o,
   output logic [SET_W-1:0]           wr_set_o,
   output logic [WAY_W-1:0]           wr_way_o,
   output logic [WORD_W-1:0]          wr_word_o,
   output data_t                      wr_data_o,
   output strb_t                      wr_strb_o,
   output logic                       tag_wr_o,
   output logic [TAG_W-1:0]           tag_o,
   output logic                       inval_all_o,
   // replacement
   input  logic [WAY_W-1:0]           victim_i,
   output logic                       repl_adv_o,
   // statistics events
   output logic                       ev_rd_hit_o,
   output logic                       ev_rd_miss_o,
   output logic                       ev_wr_hit_o,
   output logic                       ev_wr_miss_o
);

   ctrl_state_t state_q, state_d;
   fe_req_t     req_q;
   logic [WORD_W-1:0] beat_q;
   data_t       rsp_data_q;
   logic        rsp_valid_q;
   logic        inval_pend_q;

   logic [TAG_W-1:0]  req_tag;
   logic [SET_W-1:0]  req_set;
   logic [WORD_W-1:0] req_word;
   logic              is_wr;
   logic [NWAYS-1:0]  hit_vec;
   logic              hit;
   logic [WAY_W-1:0]  hit_way;
   logic              accept;
   logic              rsp_beat;
   logic              last_beat;
   logic              in_refill;

   // address is {tag, set, word}
   assign req_tag  = req_q.addr[ADDR_W-1 -: TAG_W];
   assign req_set  = req_q.addr[WORD_W +: SET_W];
   assign req_word = req_q.addr[WORD_W-1:0];
   assign is_wr    = |req_q.strb;

   // tag compare across all ways
   always_comb begin
      for (int w = 0; w < NWAYS; w++) begin
         hit_vec[w] = valids_i[w] && (tags_i[w] == req_tag);
      end
   end

   assign hit = |hit_vec;

   always_comb begin
      hit_way = '0;
      for (int w = 0; w < NWAYS; w++) begin
         if (hit_vec[w]) begin
            hit_way = WAY_W'(w);
         end
      end
   end

   // pending invalidate wins over a new request
   assign inval_all_o    = (state_q == idle) && (invalidate_i || inval_pend_q);
   // no request is taken while reset is high
   assign fe_req_ready_o = (state_q == idle) && !inval_all_o && !rst_i;
   assign accept         = fe_req_valid_i && fe_req_ready_o;

   assign in_refill = (state_q == refill_wait);
   assign rsp_beat  = in_refill && be_rsp_valid_i;
   assign last_beat = (beat_q == WORD_W'(LINE_WORDS - 1));

   always_comb begin
      state_d = state_q;
      case (state_q)
         idle: begin
            if (accept) state_d = lookup;
         end
         lookup: begin
            if (is_wr) state_d = write_thru;
            else if (hit) state_d = respond;
            else state_d = refill_req;
         end
         refill_req: begin
            if (be_req_ready_i) state_d = refill_wait;
         end
         refill_wait: begin
            if (be_rsp_valid_i) state_d = last_beat ? respond : refill_req;
         end
         write_thru: begin
            if (be_req_ready_i) state_d = respond;
         end
         respond: begin
            if (fe_rsp_ready_i) state_d = idle;
         end
         default: state_d = idle;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q      <= idle;
         beat_q       <= '0;
         rsp_valid_q  <= 1'b0;
         inval_pend_q <= 1'b0;
      end else begin
         state_q <= state_d;
         if (accept) begin
            beat_q <= '0;
         end else if (rsp_beat) begin
            beat_q <= beat_q + 1'b1;
         end
         if (state_d == respond && state_q != respond) begin
            rsp_valid_q <= 1'b1;
         end else if (rsp_valid_q && fe_rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
         end
         // hold an invalidate that arrives while busy
         if (inval_all_o) begin
            inval_pend_q <= 1'b0;
         end else if (invalidate_i) begin
            inval_pend_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         req_q <= fe_req_i;
      end
      if (state_q == lookup) begin
         rsp_data_q <= is_wr ? '0 : words_i[hit_way];
      end else if (rsp_beat && beat_q == req_word) begin
         rsp_data_q <= be_rsp_i.data;
      end
   end

   assign fe_rsp_valid_o = rsp_valid_q;
   assign fe_rsp_o.data  = rsp_data_q;

   // refill beats read the line in word order
   assign be_req_valid_o = (state_q == refill_req) || (state_q == write_thru);
   always_comb begin
      if (state_q == write_thru) begin
         be_req_o.addr = req_q.addr;
         be_req_o.data = req_q.data;
         be_req_o.strb = req_q.strb;
         be_req_o.we   = 1'b1;
      end else begin
         be_req_o.addr = {req_tag, req_set, beat_q};
         be_req_o.data = '0;
         be_req_o.strb = '0;
         be_req_o.we   = 1'b0;
      end
   end
   assign be_rsp_ready_o = in_refill;

   // array read address follows the incoming request while idle
   assign rd_set_o  = (state_q == idle) ? fe_req_i.addr[WORD_W +: SET_W] : req_set;
   assign rd_word_o = (state_q == idle) ? fe_req_i.addr[WORD_W-1:0] : req_word;

   assign wr_en_o   = ((state_q == lookup) && is_wr && hit) || rsp_beat;
   assign wr_set_o  = req_set;
   assign wr_way_o  = in_refill ? victim_i : hit_way;
   assign wr_word_o = in_refill ? beat_q : req_word;
   assign wr_data_o = in_refill ? be_rsp_i.data : req_q.data;
   assign wr_strb_o = in_refill ? '1 : req_q.strb;

   // tag and valid land with the last beat
   assign tag_wr_o   = rsp_beat && last_beat;
   assign tag_o      = req_tag;
   assign repl_adv_o = tag_wr_o;

   assign ev_rd_hit_o  = (state_q == lookup) && !is_wr && hit;
   assign ev_rd_miss_o = (state_q == lookup) && !is_wr && !hit;
   assign ev_wr_hit_o  = (state_q == lookup) && is_wr && hit;
   assign ev_wr_miss_o = (state_q == lookup) && is_wr && !hit;

   a_hit_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
      state_q == lookup |-> $onehot0(hit_vec));

   a_rsp_in_respond: assert property (@(posedge clk_i) disable iff (rst_i)
      rsp_valid_q |-> state_q == respond);

endmodule

//--- src/cache_stats.sv
module cache_stats import cache_pkg::*; (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      ev_rd_hit_i,
   input  logic      ev_rd_miss_i,
   input  logic      ev_wr_hit_i,
   input  logic      ev_wr_miss_i,
   input  stat_sel_t sel_i,
   input  logic      clear_i,
   output cnt_t      stat_o
);

   cnt_t       cnt_q [4];
   logic [3:0] ev;

   // bit order follows stat_sel_t
   assign ev = {ev_wr_miss_i, ev_wr_hit_i, ev_rd_miss_i, ev_rd_hit_i};

   always_ff @(posedge clk_i) begin
      if (rst_i || clear_i) begin
         for (int i = 0; i < 4; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 4; i++) begin
            // saturate instead of wrapping
            if (ev[i] && cnt_q[i] != '1) begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   assign stat_o = cnt_q[sel_i];

endmodule

//--- src/cache_top.sv
module cache_top import cache_pkg::*; #(
   parameter int NWAYS      = 2,
   parameter int NSETS      = 16,
   parameter int LINE_WORDS = 4,
   localparam int WAY_W     = (NWAYS > 1) ? $clog2(NWAYS) : 1,
   localparam int SET_W     = $clog2(NSETS),
   localparam int WORD_W    = $clog2(LINE_WORDS),
   localparam int TAG_W     = ADDR_W - SET_W - WORD_W
) (
   input  logic      clk_i,
   input  logic      rst_i,
   input  logic      fe_req_valid_i,
   input  fe_req_t   fe_req_i,
   output logic      fe_req_ready_o,
   output logic      fe_rsp_valid_o,
   output fe_rsp_t   fe_rsp_o,
   input  logic      fe_rsp_ready_i,
   output logic      be_req_valid_o,
   output be_req_t   be_req_o,
   input  logic      be_req_ready_i,
   input  logic      be_rsp_valid_i,
   input  be_rsp_t   be_rsp_i,
   output logic      be_rsp_ready_o,
   input  logic      invalidate_i,
   input  stat_sel_t stat_sel_i,
   input  logic      stat_clear_i,
   output cnt_t      stat_o
);

   logic [SET_W-1:0]            rd_set;
   logic [WORD_W-1:0]           rd_word;
   logic [NWAYS-1:0][TAG_W-1:0] tags;
   logic [NWAYS-1:0]            valids;
   data_t [NWAYS-1:0]           words;
   logic                        wr_en;
   logic [SET_W-1:0]            wr_set;
   logic [WAY_W-1:0]            wr_way;
   logic [WORD_W-1:0]           wr_word;
   data_t                       wr_data;
   strb_t                       wr_strb;
   logic                        tag_wr;
   logic [TAG_W-1:0]            tag;
   logic                        inval_all;
   logic [WAY_W-1:0]            victim;
   logic                        repl_adv;
   logic                        ev_rd_hit, ev_rd_miss, ev_wr_hit, ev_wr_miss;

   cache_ctrl #(.NWAYS(NWAYS), .NSETS(NSETS), .LINE_WORDS(LINE_WORDS)) ctrl_i (
      .clk_i, .rst_i,
      .fe_req_valid_i, .fe_req_i, .fe_req_ready_o,
      .fe_rsp_valid_o, .fe_rsp_o, .fe_rsp_ready_i,
      .be_req_valid_o, .be_req_o, .be_req_ready_i,
      .be_rsp_valid_i, .be_rsp_i, .be_rsp_ready_o,
      .invalidate_i,
      .rd_set_o(rd_set), .rd_word_o(rd_word),
      .tags_i(tags), .valids_i(valids), .words_i(words),
      .wr_en_o(wr_en), .wr_set_o(wr_set), .wr_way_o(wr_way), .wr_word_o(wr_word),
      .wr_data_o(wr_data), .wr_strb_o(wr_strb),
      .tag_wr_o(tag_wr), .tag_o(tag), .inval_all_o(inval_all),
      .victim_i(victim), .repl_adv_o(repl_adv),
      .ev_rd_hit_o(ev_rd_hit), .ev_rd_miss_o(ev_rd_miss),
      .ev_wr_hit_o(ev_wr_hit), .ev_wr_miss_o(ev_wr_miss)
   );

   cache_mem #(.NWAYS(NWAYS), .NSETS(NSETS), .LINE_WORDS(LINE_WORDS)) mem_i (
      .clk_i, .rst_i,
      .rd_set_i(rd_set), .rd_word_i(rd_word),
      .tags_o(tags), .valids_o(valids), .words_o(words),
      .wr_en_i(wr_en), .wr_set_i(wr_set), .wr_way_i(wr_way), .wr_word_i(wr_word),
      .wr_data_i(wr_data), .wr_strb_i(wr_strb),
      .tag_wr_i(tag_wr), .tag_i(tag), .inval_all_i(inval_all)
   );

   // pointer is looked up by the set being refilled
   way_replace #(.NWAYS(NWAYS), .NSETS(NSETS)) repl_i (
      .clk_i, .rst_i,
      .set_i(wr_set), .adv_i(repl_adv), .victim_o(victim)
   );

   cache_stats stats_i (
      .clk_i, .rst_i,
      .ev_rd_hit_i(ev_rd_hit), .ev_rd_miss_i(ev_rd_miss),
      .ev_wr_hit_i(ev_wr_hit), .ev_wr_miss_i(ev_wr_miss),
      .sel_i(stat_sel_i), .clear_i(stat_clear_i), .stat_o
   );

endmodule

//--- dv/mem_model.sv
module mem_model import cache_pkg::*; (
   input  logic    clk_i,
   input  logic    rst_i,
   input  logic    req_valid_i,
   input  be_req_t req_i,
   output logic    req_ready_o,
   output logic    rsp_valid_o,
   output be_rsp_t rsp_o,
   input  logic    rsp_ready_i
);

   data_t mem [2**ADDR_W];
   logic  busy_q;
   int    delay_q;
   int    delay;

   // every word differs from its neighbours and from its address alone
   function automatic data_t fill_word(input addr_t a);
      return {2'b10, a, 2'b01, ~a};
   endfunction

   initial begin
      req_ready_o <= 1'b0;
      rsp_valid_o <= 1'b0;
      rsp_o       <= '0;
      for (int a = 0; a < 2**ADDR_W; a++) begin
         mem[a] <= fill_word(addr_t'(a));
      end
   end

   always @(posedge clk_i) begin
      if (rst_i) begin
         req_ready_o <= 1'b0;
         rsp_valid_o <= 1'b0;
         rsp_o       <= '0;
         busy_q      <= 1'b0;
         delay_q     <= 0;
      end else begin
         // random ready, never while a read is outstanding
         req_ready_o <= !busy_q && !(req_valid_i && req_ready_o) &&
                        ($urandom_range(0, 3) != 0);
         if (req_valid_i && req_ready_o) begin
            if (req_i.we) begin
               for (int b = 0; b < 4; b++) begin
                  if (req_i.strb[b]) begin
                     mem[req_i.addr][8*b +: 8] <= req_i.data[8*b +: 8];
                  end
               end
            end else begin
               delay = $urandom_range(0, 3);
               busy_q     <= 1'b1;
               rsp_o.data <= mem[req_i.addr];
               if (delay == 0) begin
                  rsp_valid_o <= 1'b1;
               end else begin
                  delay_q <= delay;
               end
            end
         end
         if (busy_q && !rsp_valid_o) begin
            if (delay_q == 1) begin
               rsp_valid_o <= 1'b1;
            end
            delay_q <= delay_q - 1;
         end
         if (rsp_valid_o && rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
            busy_q      <= 1'b0;
         end
      end
   end

endmodule

//--- dv/tb_cache.sv
module tb_cache import cache_pkg::*; ();

   localparam int NWAYS      = 2;
   localparam int NSETS      = 16;
   localparam int LINE_WORDS = 4;
   localparam int SET_W      = $clog2(NSETS);
   localparam int WORD_W     = $clog2(LINE_WORDS);
   localparam int TAG_W      = ADDR_W - SET_W - WORD_W;
   localparam int PERIOD     = 100;
   localparam int PHASES     = 5;
   localparam int CYCLE_LIMIT = 2000;

   logic      clk_i;
   logic      rst_i;
   logic      fe_req_valid_i;
   fe_req_t   fe_req_i;
   logic      fe_req_ready_o;
   logic      fe_rsp_valid_o;
   fe_rsp_t   fe_rsp_o;
   logic      fe_rsp_ready_i;
   logic      be_req_valid_o;
   be_req_t   be_req_o;
   logic      be_req_ready_i;
   logic      be_rsp_valid_i;
   be_rsp_t   be_rsp_i;
   logic      be_rsp_ready_o;
   logic      invalidate_i;
   stat_sel_t stat_sel_i;
   logic      stat_clear_i;
   cnt_t      stat_o;

   // reference model of contents, tags, valid bits and pointers
   data_t            shadow [2**ADDR_W];
   logic [TAG_W-1:0] pred_tag [NWAYS][NSETS];
   logic             pred_valid [NWAYS][NSETS];
   int               pred_ptr [NSETS];
   cnt_t             exp_cnt [4];

   data_t exp_data;
   logic  exp_fast;
   addr_t exp_addr;
   data_t exp_wdata;
   strb_t exp_strb;
   logic  stat_check;
   cnt_t  exp_stat;
   logic  req_fire;
   int    ready_hold;

   cache_top #(.NWAYS(NWAYS), .NSETS(NSETS), .LINE_WORDS(LINE_WORDS)) dut_i (
      .clk_i, .rst_i,
      .fe_req_valid_i, .fe_req_i, .fe_req_ready_o,
      .fe_rsp_valid_o, .fe_rsp_o, .fe_rsp_ready_i,
      .be_req_valid_o, .be_req_o, .be_req_ready_i,
      .be_rsp_valid_i, .be_rsp_i, .be_rsp_ready_o,
      .invalidate_i, .stat_sel_i, .stat_clear_i, .stat_o
   );

   mem_model backend_i (
      .clk_i, .rst_i,
      .req_valid_i(be_req_valid_o), .req_i(be_req_o), .req_ready_o(be_req_ready_i),
      .rsp_valid_o(be_rsp_valid_i), .rsp_o(be_rsp_i), .rsp_ready_i(be_rsp_ready_o)
   );

   assign req_fire = fe_req_valid_i && fe_req_ready_o;

   task automatic report_mismatch(input string msg);
      $display("mismatch at time %0t: %s", $time, msg);
      $display("Verification failed");
      $fatal(1, "stopping at first error");
   endtask

   task automatic report_failure(input string msg);
      $display("error at time %0t: %s", $time, msg);
      $display("Verification failed");
      $fatal(1, "stopping at first error");
   endtask

   a_read_data: assert property (@(posedge clk_i) disable iff (rst_i)
      fe_rsp_valid_o |-> fe_rsp_o.data == exp_data)
      else report_mismatch("response data differs from the shadow memory");

   a_hit_latency: assert property (@(posedge clk_i) disable iff (rst_i)
      $past(req_fire, 2) && exp_fast |-> fe_rsp_valid_o)
      else report_failure("predicted read hit was not answered one cycle after acceptance");

   a_rsp_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      $past(fe_rsp_valid_o && !fe_rsp_ready_i) |-> fe_rsp_valid_o && $stable(fe_rsp_o.data))
      else report_failure("stalled response dropped or changed before its transfer");

   a_busy_no_accept: assert property (@(posedge clk_i) disable iff (rst_i)
      fe_rsp_valid_o |-> !fe_req_ready_o)
      else report_failure("request ready raised while a response is pending");

   a_write_thru: assert property (@(posedge clk_i) disable iff (rst_i)
      be_req_valid_o && be_req_o.we |->
         be_req_o.addr == exp_addr && be_req_o.data == exp_wdata && be_req_o.strb == exp_strb)
      else report_mismatch("back-end write does not carry the front-end request");

   a_be_rsp_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      be_rsp_valid_i |-> be_rsp_ready_o)
      else report_failure("back-end read data was not taken while the refill waits for it");

   a_counter: assert property (@(posedge clk_i) disable iff (rst_i)
      stat_check |-> stat_o == exp_stat)
      else report_mismatch("statistics counter differs from the model count");

   a_reset_quiet: assert property (@(posedge clk_i)
      rst_i && $past(rst_i) |-> !be_req_valid_o && !fe_rsp_valid_o && !fe_req_ready_o)
      else report_failure("valid or ready output raised during reset");

   function automatic data_t fill_word(input addr_t a);
      return {2'b10, a, 2'b01, ~a};
   endfunction

   // address layout is {tag, set, word}
   function automatic addr_t compose_addr(input int tag, input int set, input int word);
      return addr_t'((tag << (SET_W + WORD_W)) | (set << WORD_W) | word);
   endfunction

   task automatic next_cycle();
      @(posedge clk_i);
      #10;
   endtask

   task automatic predict(input addr_t addr, input data_t data, input strb_t strb);
      logic [SET_W-1:0] s;
      logic [TAG_W-1:0] t;
      logic             hit;
      int               victim;
      s   = addr[WORD_W +: SET_W];
      t   = addr[ADDR_W-1 -: TAG_W];
      hit = 1'b0;
      for (int w = 0; w < NWAYS; w++) begin
         if (pred_valid[w][s] && pred_tag[w][s] == t) begin
            hit = 1'b1;
         end
      end
      exp_addr  = addr;
      exp_wdata = data;
      exp_strb  = strb;
      if (strb == '0) begin
         exp_data = shadow[addr];
         exp_fast = hit;
         if (hit) begin
            exp_cnt[0] = exp_cnt[0] + 1;
         end else begin
            // refill into the round-robin victim
            exp_cnt[1] = exp_cnt[1] + 1;
            victim = pred_ptr[s];
            pred_tag[victim][s]   = t;
            pred_valid[victim][s] = 1'b1;
            pred_ptr[s] = (victim + 1) % NWAYS;
         end
      end else begin
         exp_data = '0;
         exp_fast = 1'b0;
         if (hit) begin
            exp_cnt[2] = exp_cnt[2] + 1;
         end else begin
            exp_cnt[3] = exp_cnt[3] + 1;
         end
         for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
               shadow[addr][8*b +: 8] = data[8*b +: 8];
            end
         end
      end
   endtask

   // one full request from valid to response transfer
   task automatic run_request(input addr_t addr, input data_t data, input strb_t strb);
      predict(addr, data, strb);
      fe_req_i.addr  = addr;
      fe_req_i.data  = data;
      fe_req_i.strb  = strb;
      fe_req_valid_i = 1'b1;
      @(negedge clk_i);
      while (!fe_req_ready_o) @(negedge clk_i);
      next_cycle();
      fe_req_valid_i = 1'b0;
      @(negedge clk_i);
      while (!(fe_rsp_valid_o && fe_rsp_ready_i)) @(negedge clk_i);
      next_cycle();
   endtask

   task automatic random_access(input logic allow_write);
      addr_t a;
      a = addr_t'($urandom_range(0, 255));
      if (allow_write && $urandom_range(0, 1) == 1) begin
         run_request(a, $urandom, strb_t'($urandom_range(1, 15)));
      end else begin
         run_request(a, '0, '0);
      end
   endtask

   task automatic check_counters();
      for (int i = 0; i < 4; i++) begin
         stat_sel_i = stat_sel_t'(i);
         exp_stat   = exp_cnt[i];
         stat_check = 1'b1;
         next_cycle();
      end
      stat_check = 1'b0;
   endtask

   task automatic invalidate_all();
      invalidate_i = 1'b1;
      for (int w = 0; w < NWAYS; w++) begin
         for (int s = 0; s < NSETS; s++) begin
            pred_valid[w][s] = 1'b0;
         end
      end
      next_cycle();
      invalidate_i = 1'b0;
   endtask

   task automatic clear_counters();
      stat_clear_i = 1'b1;
      next_cycle();
      stat_clear_i = 1'b0;
      for (int i = 0; i < 4; i++) begin
         exp_cnt[i] = '0;
      end
   endtask

   initial begin
      clk_i = 1'b0;
      forever #(PERIOD / 2) clk_i = ~clk_i;
   end

   // response ready low or high for random stretches
   initial begin
      forever begin
         @(posedge clk_i);
         #10;
         if (ready_hold == 0) begin
            fe_rsp_ready_i = ($urandom_range(0, 2) != 0);
            ready_hold = $urandom_range(1, 6);
         end
         ready_hold = ready_hold - 1;
      end
   end

   initial begin
      #(PHASES * CYCLE_LIMIT * PERIOD);
      $display("timeout: the run did not finish within %0d cycles", PHASES * CYCLE_LIMIT);
      $display("Verification failed");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(83));
      rst_i          = 1'b1;
      fe_req_valid_i = 1'b0;
      fe_req_i       = '0;
      fe_rsp_ready_i = 1'b0;
      invalidate_i   = 1'b0;
      stat_sel_i     = stat_rd_hit;
      stat_clear_i   = 1'b0;
      stat_check     = 1'b0;
      exp_stat       = '0;
      exp_data       = '0;
      exp_fast       = 1'b0;
      exp_addr       = '0;
      exp_wdata      = '0;
      exp_strb       = '0;
      ready_hold     = 0;
      for (int a = 0; a < 2**ADDR_W; a++) begin
         shadow[a] = fill_word(addr_t'(a));
      end
      for (int s = 0; s < NSETS; s++) begin
         pred_ptr[s] = 0;
         for (int w = 0; w < NWAYS; w++) begin
            pred_valid[w][s] = 1'b0;
            pred_tag[w][s]   = '0;
         end
      end
      for (int i = 0; i < 4; i++) begin
         exp_cnt[i] = '0;
      end
      repeat (2) @(posedge clk_i);
      #10;
      rst_i = 1'b0;

      // reads only over a few tags per set
      repeat (40) random_access(1'b0);
      check_counters();

      // strobed writes mixed with reads
      repeat (40) random_access(1'b1);
      check_counters();

      // NWAYS+1 lines fighting over set 5
      for (int r = 0; r < 3; r++) begin
         for (int t = 1; t <= NWAYS + 1; t++) begin
            run_request(compose_addr(t, 5, 2), '0, '0);
         end
      end
      check_counters();

      // last line read above was cached and must miss now
      invalidate_all();
      run_request(compose_addr(NWAYS + 1, 5, 1), '0, '0);
      check_counters();

      clear_counters();
      check_counters();

      $display("Verification passed");
      $finish;
   end

endmodule

//--- list.f
common/cache_pkg.sv
cache/way_replace.sv
cache/cache_mem.sv
cache/cache_ctrl.sv
src/cache_stats.sv
src/cache_top.sv
dv/mem_model.sv
dv/tb_cache.sv

//--- Makefile
SIM    := verilator
FLAGS  := --binary --timing --assert -j 0
TOP    := tb_cache
FLIST  := list.f
OBJDIR := obj_dir
LOG    := sim.log

BIN  := $(OBJDIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
